// File: FetchFrontEnd.f
src/FetchTypes.sv
src/NextPcStage.sv
src/FetchLane.sv
src/FetchPacker.sv
src/FetchFrontEnd.sv
test/FetchFrontEndTb.sv

// File: run.sh
#!/bin/sh
# Compile and run the fetch front end testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module FetchFrontEndTb -f FetchFrontEnd.f

output=$(./obj_dir/VFetchFrontEndTb)
echo "$output"

# Fails the script unless the pass line is present
echo "$output" | grep -qxF '** PASS **'

// File: src/FetchFrontEnd.sv
/*
 * Top level of the fetch front end. Connects the next-PC stage, one
 * fetch lane per slot and the packer. Parameters set here are passed
 * down to every block.
 */

module FetchFrontEnd #(
    parameter int fetchWidth = 4,
    parameter int btbEntries = 16,
    parameter int lineBytes = 32,
    parameter FetchTypes::PcPath resetPc = 32'h1000
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 stall,
    input  FetchTypes::Redirect  recover,
    input  FetchTypes::Redirect  interrupt,
    input  FetchTypes::BtbTrain  train,
    output FetchTypes::PcPath    fetchAddr,
    output FetchTypes::FetchSlot packet [fetchWidth]
);

    FetchTypes::FetchSlot group [fetchWidth];
    FetchTypes::LaneView views [fetchWidth];
    FetchTypes::BranchPrediction prediction;
    logic flush;

    NextPcStage #(
        .fetchWidth(fetchWidth),
        .lineBytes(lineBytes),
        .resetPc(resetPc)
    ) NextPcStage_inst (
        .clk(clk),
        .rst(rst),
        .stall(stall),
        .recover(recover),
        .interrupt(interrupt),
        .prediction(prediction),
        .group(group),
        .fetchAddr(fetchAddr),
        .flush(flush)
    );

    // Training is broadcast, each lane picks its own word offset
    for (genvar i = 0; i < fetchWidth; i++) begin : laneGen
        FetchLane #(
            .laneIndex(i),
            .fetchWidth(fetchWidth),
            .btbEntries(btbEntries)
        ) FetchLane_inst (
            .clk(clk),
            .rst(rst),
            .stall(stall),
            .flush(flush),
            .slotIn(group[i]),
            .train(train),
            .view(views[i])
        );
    end

    FetchPacker #(
        .fetchWidth(fetchWidth)
    ) FetchPacker_inst (
        .views(views),
        .packet(packet),
        .prediction(prediction)
    );

endmodule

// File: src/FetchLane.sv
/*
 * One fetch lane. Registers its slot of the fetch group together with
 * a lookup in its own bank of the direct-mapped BTB. The bank learns
 * only branches whose word offset in the group equals the lane index.
 */

module FetchLane #(
    parameter int laneIndex = 0,
    parameter int fetchWidth = 4,
    parameter int btbEntries = 16
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 stall,
    input  logic                 flush,
    input  FetchTypes::FetchSlot slotIn,
    input  FetchTypes::BtbTrain  train,
    output FetchTypes::LaneView  view
);

    localparam int pcBits = $bits(FetchTypes::PcPath);
    localparam int wordBits = $clog2(FetchTypes::InsnBytes);
    localparam int laneBits = $clog2(fetchWidth);
    localparam int offsetBits = wordBits + laneBits;
    localparam int indexBits = $clog2(btbEntries);
    localparam int tagBits = pcBits - offsetBits - indexBits;
    localparam logic [laneBits-1:0] laneId = laneBits'(laneIndex);

    logic [tagBits-1:0] tagMem [btbEntries];
    FetchTypes::PcPath targetMem [btbEntries];
    logic [btbEntries-1:0] takenBits;
    logic [btbEntries-1:0] entryValid;

    logic [indexBits-1:0] readIndex;
    logic [indexBits-1:0] writeIndex;
    logic bankWrite;
    logic lookupHit;

    assign readIndex = slotIn.pc[offsetBits +: indexBits];
    assign writeIndex = train.pc[offsetBits +: indexBits];
    assign bankWrite = train.valid && train.pc[offsetBits-1:wordBits] == laneId;

    // A slot at another word offset never matches this bank
    assign lookupHit = entryValid[readIndex]
        && tagMem[readIndex] == slotIn.pc[pcBits-1 -: tagBits]
        && slotIn.pc[offsetBits-1:wordBits] == laneId;

    always_ff @(posedge clk) begin
        if (rst) begin
            entryValid <= '0;
        end
        else if (bankWrite) begin
            entryValid[writeIndex] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (bankWrite) begin
            tagMem[writeIndex] <= train.pc[pcBits-1 -: tagBits];
            targetMem[writeIndex] <= train.target;
            takenBits[writeIndex] <= train.taken;
        end
    end

    // Flush wins over stall so recovery acts at once
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            view.slot.valid <= 1'b0;
        end
        else if (!stall) begin
            view.slot <= slotIn;
            view.btbHit <= lookupHit;
            view.predTaken <= takenBits[readIndex];
            view.target <= targetMem[readIndex];
        end
    end

endmodule

// File: src/FetchPacker.sv
/*
 * Packer for the fetch lanes. Cuts the group after the first valid
 * slot that hits in the BTB and is predicted taken, and sends that
 * target back to the next-PC stage.
 */

module FetchPacker #(
    parameter int fetchWidth = 4
) (
    input  FetchTypes::LaneView         views [fetchWidth],
    output FetchTypes::FetchSlot        packet [fetchWidth],
    output FetchTypes::BranchPrediction prediction
);

    logic [fetchWidth-1:0] takenMask;

    // Lanes holding a live predicted-taken branch
    always_comb begin
        for (int i = 0; i < fetchWidth; i++) begin
            takenMask[i] = views[i].slot.valid && views[i].btbHit && views[i].predTaken;
        end
    end

    // Lowest taken lane wins, later lanes are off the predicted path
    always_comb begin
        logic cut;

        cut = 1'b0;
        prediction.redirect = 1'b0;
        prediction.target = '0;
        for (int i = 0; i < fetchWidth; i++) begin
            packet[i] = views[i].slot;
            if (cut) begin
                packet[i].valid = 1'b0;
            end
            else if (takenMask[i]) begin
                cut = 1'b1;
                prediction.redirect = 1'b1;
                prediction.target = views[i].target;
            end
        end
    end

endmodule

// File: src/FetchTypes.sv
/*
 * Shared types of the fetch front end: addresses, instruction slots,
 * lane outputs, branch predictions, redirects and BTB training writes.
 * Modules refer to these by scoped name.
 */

package FetchTypes;

    // Byte address of an instruction
    typedef logic [31:0] PcPath;

    // Size of one instruction in bytes
    localparam int InsnBytes = 4;

    // Serial number given to every fetched slot
    typedef logic [15:0] SerialId;

    // One instruction slot in flight
    typedef struct packed {
        logic    valid;
        PcPath   pc;
        SerialId sid;
    } FetchSlot;

    // Registered output of one fetch lane with its BTB lookup result
    typedef struct packed {
        FetchSlot slot;
        logic     btbHit;
        logic     predTaken;
        PcPath    target;
    } LaneView;

    // Packer feedback that steers the next fetch group
    typedef struct packed {
        logic  redirect;
        PcPath target;
    } BranchPrediction;

    // Recovery or interrupt request, a one-cycle strobe
    typedef struct packed {
        logic  valid;
        PcPath pc;
    } Redirect;

    // Training write from the back end
    typedef struct packed {
        logic  valid;
        PcPath pc;
        PcPath target;
        logic  taken;
    } BtbTrain;

endpackage

// File: src/NextPcStage.sv
/*
 * Next-PC stage. Picks the base address of the next fetch group from
 * recovery, the packer prediction or the PC register, splits the group
 * at the cache line boundary and numbers every slot with a serial id.
 */

module NextPcStage #(
    parameter int fetchWidth = 4,
    parameter int lineBytes = 32,
    parameter FetchTypes::PcPath resetPc = 32'h1000
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        stall,
    input  FetchTypes::Redirect         recover,
    input  FetchTypes::Redirect         interrupt,
    input  FetchTypes::BranchPrediction prediction,
    output FetchTypes::FetchSlot        group [fetchWidth],
    output FetchTypes::PcPath           fetchAddr,
    output logic                        flush
);

    localparam int pcBits = $bits(FetchTypes::PcPath);
    localparam int lineBits = $clog2(lineBytes);
    localparam int countBits = $clog2(fetchWidth) + 1;

    FetchTypes::PcPath pcReg;
    FetchTypes::PcPath base;
    FetchTypes::SerialId sidReg;
    logic [countBits-1:0] validCount;
    logic loadSequential;

    // Base priority: recovery, then a taken prediction, then the PC register
    always_comb begin
        if (recover.valid) begin
            base = recover.pc;
        end
        else if (prediction.redirect && !stall) begin
            base = prediction.target;
        end
        else begin
            base = pcReg;
        end
    end

    // Slots run from the base and stop at the end of its cache line
    always_comb begin
        FetchTypes::PcPath slotPc;
        logic sameLine;

        validCount = '0;
        for (int i = 0; i < fetchWidth; i++) begin
            slotPc = base + FetchTypes::PcPath'(i * FetchTypes::InsnBytes);
            sameLine = slotPc[pcBits-1:lineBits] == base[pcBits-1:lineBits];
            group[i].pc = slotPc;
            group[i].sid = sidReg + FetchTypes::SerialId'(i);
            group[i].valid = sameLine && !recover.valid && !interrupt.valid;
            if (group[i].valid) begin
                validCount = validCount + countBits'(1);
            end
        end
    end

    // Recovery and interrupt still move the PC while stalled
    assign loadSequential = !interrupt.valid && (recover.valid || !stall);

    always_ff @(posedge clk) begin
        if (rst) begin
            pcReg <= resetPc;
            sidReg <= FetchTypes::SerialId'(1);
        end
        else if (interrupt.valid) begin
            // Interrupt address bypasses the base mux
            pcReg <= interrupt.pc;
        end
        else if (loadSequential) begin
            pcReg <= base + FetchTypes::PcPath'(validCount * FetchTypes::InsnBytes);
            sidReg <= sidReg + FetchTypes::SerialId'(validCount);
        end
    end

    // Stands in for the instruction cache request
    assign fetchAddr = base;

    // Lanes drop their contents even when stalled
    assign flush = recover.valid || interrupt.valid;

endmodule

// File: test/FetchFrontEndTb.sv
/*
 * Testbench for the fetch front end. Trains a few BTB entries, then runs
 * random stall, recovery and interrupt traffic while a reference model
 * predicts the base and length of every packet.
 */

module FetchFrontEndTb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int fetchWidth = 4;
    localparam int lineBytes = 32;
    localparam int resetCycles = 16;
    localparam int testCycles = 3000;
    // Reset, training and the random run take about 3030 cycles
    localparam int watchdogCycles = 4000;
    localparam FetchTypes::PcPath resetPc = 32'h1000;

    logic clk;
    logic rst;
    logic stall;
    FetchTypes::Redirect recover;
    FetchTypes::Redirect interrupt;
    FetchTypes::BtbTrain train;
    FetchTypes::PcPath fetchAddr;
    FetchTypes::FetchSlot packet [fetchWidth];
    FetchTypes::FetchSlot lastPacket [fetchWidth];

    // Reference BTB, one entry per word slot index (pc bits 7 to 2)
    logic refValid [64];
    FetchTypes::PcPath refPc [64];
    FetchTypes::PcPath refTarget [64];
    logic refTaken [64];

    FetchTypes::PcPath expBase;
    FetchTypes::PcPath expFetch;
    logic fetchKnown;
    FetchTypes::SerialId lastSid;
    logic prevStall;
    logic prevEvent;
    int mismatches;
    int failures;

    FetchFrontEnd FetchFrontEnd_inst (
        .clk(clk),
        .rst(rst),
        .stall(stall),
        .recover(recover),
        .interrupt(interrupt),
        .train(train),
        .fetchAddr(fetchAddr),
        .packet(packet)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic reportMismatch(string name, logic [63:0] got, logic [63:0] exp);
        mismatches++;
        $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
    endtask

    task automatic reportFailure(string what);
        failures++;
        $display("error at %0t: %s", $time, what);
    endtask

    // The address looked up must be the base of the group the lanes take next
    fetchAddrMatch: assert property (@(posedge clk) disable iff (rst)
        fetchKnown |-> fetchAddr == expFetch)
        else reportMismatch("fetchAddr", 64'($sampled(fetchAddr)), 64'($sampled(expFetch)));

    // A slot only hits in the bank of its own lane
    function automatic logic predictTaken(FetchTypes::PcPath pc, int lane);
        return pc[3:2] == 2'(lane) && refValid[pc[7:2]] && refPc[pc[7:2]] == pc
            && refTaken[pc[7:2]];
    endfunction

    function automatic int expectedCount(FetchTypes::PcPath base);
        int n;
        n = (lineBytes - int'(base[4:0])) / 4;
        if (n > fetchWidth) begin
            n = fetchWidth;
        end
        for (int i = 0; i < n; i++) begin
            if (predictTaken(base + FetchTypes::PcPath'(4 * i), i)) begin
                return i + 1;
            end
        end
        return n;
    endfunction

    task automatic trainEntry(FetchTypes::PcPath pc, FetchTypes::PcPath target, logic taken);
        @(negedge clk);
        train.valid = 1'b1;
        train.pc = pc;
        train.target = target;
        train.taken = taken;
        refValid[pc[7:2]] = 1'b1;
        refPc[pc[7:2]] = pc;
        refTarget[pc[7:2]] = target;
        refTaken[pc[7:2]] = taken;
    endtask

    task automatic checkPacket(output int count);
        count = 0;
        for (int i = 0; i < fetchWidth; i++) begin
            if (packet[i].valid) begin
                count++;
            end
        end
        if (prevEvent) begin
            assert (count == 0) else reportFailure("packet after a redirect is not empty");
        end
        else if (prevStall) begin
            for (int i = 0; i < fetchWidth; i++) begin
                assert (packet[i] === lastPacket[i])
                    else reportMismatch("packet while stalled", 64'(packet[i]), 64'(lastPacket[i]));
            end
        end
        else begin
            assert (count > 0) else reportFailure("empty packet after an accepted cycle");
        end
        if (count > 0) begin
            assert (packet[0].pc == expBase)
                else reportMismatch("packet[0].pc", 64'(packet[0].pc), 64'(expBase));
            assert (count == expectedCount(expBase))
                else reportMismatch("valid count", 64'(count), 64'(expectedCount(expBase)));
            for (int i = 1; i < fetchWidth; i++) begin
                if (packet[i].valid) begin
                    assert (packet[i - 1].valid) else reportFailure("valid slots not contiguous");
                    assert (packet[i].pc == packet[0].pc + FetchTypes::PcPath'(4 * i))
                        else reportMismatch("packet.pc", 64'(packet[i].pc), 64'(packet[0].pc + 4 * i));
                    assert (packet[i].sid == packet[0].sid + FetchTypes::SerialId'(i))
                        else reportMismatch("packet.sid", 64'(packet[i].sid), 64'(packet[0].sid + i));
                    assert (packet[i].pc[31:5] == packet[0].pc[31:5])
                        else reportFailure("packet crosses a cache line");
                end
            end
        end
    endtask

    initial begin
        automatic int count;
        automatic int pick;
        automatic FetchTypes::FetchSlot last;

        void'($urandom(37406));
        mismatches = 0;
        failures = 0;
        fetchKnown = 1'b0;
        expFetch = resetPc;
        rst = 1'b1;
        stall = 1'b1;
        recover = '0;
        interrupt = '0;
        train = '0;
        for (int i = 0; i < 64; i++) begin
            refValid[i] = 1'b0;
        end
        repeat (resetCycles) @(negedge clk);
        rst = 1'b0;

        // Loop of taken branches plus one not-taken entry
        trainEntry(32'h1008, 32'h1044, 1'b1);
        trainEntry(32'h1064, 32'h1020, 1'b0);
        trainEntry(32'h1078, 32'h1000, 1'b1);
        trainEntry(32'h1034, 32'h1010, 1'b1);
        @(negedge clk);
        train = '0;
        lastPacket = packet;
        prevStall = 1'b1;
        prevEvent = 1'b0;
        expBase = resetPc;
        lastSid = '0;

        repeat (testCycles) begin
            @(negedge clk);
            checkPacket(count);
            lastPacket = packet;
            recover = '0;
            interrupt = '0;
            stall = ($urandom % 4) == 0;
            pick = int'($urandom % 40);
            if (pick == 0) begin
                recover.valid = 1'b1;
                recover.pc = 32'h1000 + ($urandom % 32) * 4;
                expBase = recover.pc;
            end
            else if (pick == 1) begin
                interrupt.valid = 1'b1;
                interrupt.pc = 32'h1000 + ($urandom % 32) * 4;
                expBase = interrupt.pc;
            end
            else if (!stall && count > 0) begin
                // Packet accepted downstream
                last = packet[count - 1];
                assert (packet[0].sid > lastSid)
                    else reportMismatch("packet[0].sid", 64'(packet[0].sid), 64'(lastSid + 1));
                lastSid = last.sid;
                if (predictTaken(last.pc, count - 1)) begin
                    expBase = refTarget[last.pc[7:2]];
                end
                else begin
                    expBase = last.pc + 32'd4;
                end
            end
            // Known only when the lanes take the group at the coming edge
            fetchKnown = !interrupt.valid && (recover.valid || !stall);
            expFetch = expBase;
            prevStall = stall;
            prevEvent = recover.valid || interrupt.valid;
        end

        $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches + failures == 0) begin
            $display("** PASS **");
        end
        else begin
            $display("** FAIL **");
        end
        $finish;
    end

    initial begin
        repeat (watchdogCycles) @(posedge clk);
        $display("watchdog expired before the test finished");
        $display("** FAIL **");
        $finish;
    end

endmodule
